//--- verilog/alu_pkg.sv
// Shared ALU definitions; XLEN must be a power of two and at least 2 for the adder and shifter
package alu_pkg;

    // Datapath width
    localparam int XLEN = 32;

    // Shift amount takes the low bits of operand b
    localparam int SHAMT_W = $clog2(XLEN);

    // One multiplier iteration per multiplier bit
    localparam int MUL_CYCLES = XLEN;
    localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

    // Operation codes, fixed values so vector files stay stable
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_SLT   = 4'h2,
        OP_SLTU  = 4'h3,
        OP_AND   = 4'h4,
        OP_OR    = 4'h5,
        OP_XOR   = 4'h6,
        OP_SLL   = 4'h7,
        OP_SRL   = 4'h8,
        OP_SRA   = 4'h9,
        OP_MUL   = 4'hA,
        OP_MULHU = 4'hB
    } alu_op_t;

    // Operation classes used to steer results
    function automatic logic is_arith(alu_op_t op);
        return op inside {OP_ADD, OP_SUB, OP_SLT, OP_SLTU};
    endfunction

    function automatic logic is_logic(alu_op_t op);
        return op inside {OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA};
    endfunction

    function automatic logic is_mul(alu_op_t op);
        return op inside {OP_MUL, OP_MULHU};
    endfunction

endpackage

//--- verilog/ks_adder.sv
// Kogge-Stone adder; N of at least 2, cout is signed overflow when SIGNED is 1, else carry-out
`timescale 1ns/1ps

module ks_adder #(
    parameter int N = 16,
    parameter bit SIGNED = 0
) (
    input  logic [N-1:0] dataa,
    input  logic [N-1:0] datab,
    input  logic         cin,
    output logic [N-1:0] sum,
    output logic         cout
);
    localparam int LEVELS = $clog2(N);

    logic [N-1:0] gen0;
    logic [N-1:0] prop0;
    logic [N-1:0] gen_pre;
    logic [N-1:0] prop_pre;
    // carry[i] is the carry into bit i, carry[N] the carry out of the MSB
    logic [N:0]   carry;

    // Bitwise generate and propagate
    assign gen0  = dataa & datab;
    assign prop0 = dataa ^ datab;

    // Prefix tree, span doubles every level
    always_comb begin : prefix_tree
        logic [N-1:0] g_cur;
        logic [N-1:0] p_cur;
        logic [N-1:0] g_nxt;
        logic [N-1:0] p_nxt;
        g_cur = gen0;
        p_cur = prop0;
        for (int k = 0; k < LEVELS; k++) begin
            g_nxt = g_cur;
            p_nxt = p_cur;
            // Nodes below the span pass through unchanged
            for (int i = (1 << k); i < N; i++) begin
                g_nxt[i] = g_cur[i] | (p_cur[i] & g_cur[i - (1 << k)]);
                p_nxt[i] = p_cur[i] & p_cur[i - (1 << k)];
            end
            g_cur = g_nxt;
            p_cur = p_nxt;
        end
        gen_pre  = g_cur;
        prop_pre = p_cur;
    end

    // Group terms cover bits 0..i, so cin folds in once here
    assign carry = {gen_pre | (prop_pre & {N{cin}}), cin};
    assign sum   = prop0 ^ carry[N-1:0];

    if (SIGNED) begin : g_signed_out
        // Overflow when carry into MSB differs from carry out of it
        assign cout = carry[N] ^ carry[N-1];
    end else begin : g_unsigned_out
        assign cout = carry[N];
    end

endmodule

//--- verilog/arith_unit.sv
// Combinational add, subtract and compares; ovf is valid only for ADD and SUB
`timescale 1ns/1ps

module arith_unit import alu_pkg::*; (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result,
    output logic            ovf
);
    logic            sub;
    logic            sltu_sel;
    logic [XLEN-1:0] a_in;
    logic [XLEN-1:0] b_op;
    logic [XLEN-1:0] b_in;
    logic [XLEN-1:0] sum;
    logic            adder_ovf;
    logic            less;

    // Everything but ADD goes through a - b
    assign sub      = (op != OP_ADD);
    assign sltu_sel = (op == OP_SLTU);

    // Flipping both MSBs maps the unsigned order onto the signed one
    assign a_in = {a[XLEN-1] ^ sltu_sel, a[XLEN-2:0]};
    assign b_op = {b[XLEN-1] ^ sltu_sel, b[XLEN-2:0]};

    // Two's complement subtract, invert b and carry in a one
    assign b_in = sub ? ~b_op : b_op;

    ks_adder #(.N(XLEN), .SIGNED(1)) u_adder (
        .dataa (a_in),
        .datab (b_in),
        .cin   (sub),
        .sum   (sum),
        .cout  (adder_ovf)
    );

    // Signed less-than corrected by overflow
    assign less = sum[XLEN-1] ^ adder_ovf;

    always_comb begin
        case (op)
            OP_SLT, OP_SLTU: result = {{(XLEN-1){1'b0}}, less};
            default:         result = sum;
        endcase
    end

    assign ovf = adder_ovf & ((op == OP_ADD) | (op == OP_SUB));

endmodule

//--- verilog/logic_shift_unit.sv
// Combinational bitwise logic and shifts; shift amount is the low SHAMT_W bits of b
`timescale 1ns/1ps

module logic_shift_unit import alu_pkg::*; (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] result
);
    logic [SHAMT_W-1:0] shamt;

    // Upper bits of b play no part in shifts
    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            OP_SLL: result = a << shamt;
            OP_SRL: result = a >> shamt;
            // Sign bit replicated from the top
            OP_SRA: result = $signed(a) >>> shamt;
            // Not a logic op, the controller ignores this
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/shift_add_multiplier.sv
// Unsigned radix-2 multiplier; start must not repeat before done, product is valid while done is high
`timescale 1ns/1ps

module shift_add_multiplier import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic [2*XLEN-1:0] product,
    output logic              done
);
    logic                 running;
    logic [MUL_CNT_W-1:0] count;
    logic [XLEN-1:0]      mcand;
    logic [XLEN-1:0]      acc_hi;
    logic [XLEN-1:0]      acc_lo;
    logic [XLEN-1:0]      addend;
    logic [XLEN-1:0]      sum;
    logic                 carry;

    // Add the multiplicand only when the current multiplier bit is set
    assign addend = acc_lo[0] ? mcand : '0;

    ks_adder #(.N(XLEN), .SIGNED(0)) u_acc_adder (
        .dataa (acc_hi),
        .datab (addend),
        .cin   (1'b0),
        .sum   (sum),
        .cout  (carry)
    );

    // Iteration control
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            count   <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                // Last pass, product is final after this edge
                if (count == MUL_CNT_W'(MUL_CYCLES - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Operand and accumulator registers
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            acc_hi <= '0;
            acc_lo <= b;
        end else if (running) begin
            // Shift {carry, sum, acc_lo} right by one
            acc_hi <= {carry, sum[XLEN-1:1]};
            acc_lo <= {sum[0], acc_lo[XLEN-1:1]};
        end
    end

    assign product = {acc_hi, acc_lo};

endmodule

//--- verilog/alu_ctrl.sv
// Request control; valid_in while busy is dropped, result and ovf hold until the next completion
`timescale 1ns/1ps

module alu_ctrl import alu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_in,
    input  alu_op_t           op,
    input  logic [XLEN-1:0]   arith_result,
    input  logic              arith_ovf,
    input  logic [XLEN-1:0]   logic_result,
    input  logic [2*XLEN-1:0] mul_product,
    input  logic              mul_done,
    output logic              mul_start,
    output logic              busy,
    output logic              valid_out,
    output logic [XLEN-1:0]   result,
    output logic              ovf
);
    logic            accept;
    alu_op_t         op_q;
    logic [XLEN-1:0] single_result;
    logic            single_ovf;
    logic [XLEN-1:0] mul_result;

    // Request taken on this edge
    assign accept = valid_in & ~busy;

    // Multiplier samples a and b on the accepting edge
    assign mul_start = accept & is_mul(op);

    // One-cycle result from whichever unit owns the op
    always_comb begin
        if (is_arith(op)) begin
            single_result = arith_result;
            single_ovf    = arith_ovf;
        end else if (is_logic(op)) begin
            single_result = logic_result;
            single_ovf    = 1'b0;
        end else begin
            single_result = '0;
            single_ovf    = 1'b0;
        end
    end

    // High or low half depending on the op taken at start
    assign mul_result = (op_q == OP_MULHU) ? mul_product[2*XLEN-1:XLEN]
                                           : mul_product[XLEN-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            valid_out <= 1'b0;
            result    <= '0;
            ovf       <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            if (accept) begin
                if (is_mul(op)) begin
                    busy <= 1'b1;
                end else begin
                    valid_out <= 1'b1;
                    result    <= single_result;
                    ovf       <= single_ovf;
                end
            end else if (busy && mul_done) begin
                // Multiply finished, release the unit
                busy      <= 1'b0;
                valid_out <= 1'b1;
                result    <= mul_result;
                ovf       <= 1'b0;
            end
        end
    end

    // Pending multiply variant
    always_ff @(posedge clk) begin
        if (mul_start) begin
            op_q <= op;
        end
    end

endmodule

//--- verilog/alu_unit.sv
// ALU top; requests need valid_in high and busy low at the clock edge, no back-pressure
`timescale 1ns/1ps

module alu_unit import alu_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            valid_in,
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic            busy,
    output logic            valid_out,
    output logic [XLEN-1:0] result,
    output logic            ovf
);
    logic [XLEN-1:0]   arith_result;
    logic              arith_ovf;
    logic [XLEN-1:0]   logic_result;
    logic [2*XLEN-1:0] mul_product;
    logic              mul_done;
    logic              mul_start;

    // Sequencing and result registers
    alu_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .valid_in     (valid_in),
        .op           (op),
        .arith_result (arith_result),
        .arith_ovf    (arith_ovf),
        .logic_result (logic_result),
        .mul_product  (mul_product),
        .mul_done     (mul_done),
        .mul_start    (mul_start),
        .busy         (busy),
        .valid_out    (valid_out),
        .result       (result),
        .ovf          (ovf)
    );

    // Combinational units see the raw operands
    arith_unit u_arith (
        .op     (op),
        .a      (a),
        .b      (b),
        .result (arith_result),
        .ovf    (arith_ovf)
    );

    logic_shift_unit u_logic (
        .op     (op),
        .a      (a),
        .b      (b),
        .result (logic_result)
    );

    shift_add_multiplier u_mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (a),
        .b       (b),
        .product (mul_product),
        .done    (mul_done)
    );

endmodule

//--- tests/alu_unit_properties.sv
// Handshake assertions bound into alu_unit; needs a simulator with concurrent assertions enabled
`timescale 1ns/1ps

module alu_unit_properties import alu_pkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    valid_in,
    input alu_op_t op,
    input logic    busy,
    input logic    valid_out,
    input logic    ovf
);
    alu_op_t done_op;

    // Op of the request most recently accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            done_op <= OP_ADD;
        end else if (valid_in && !busy) begin
            done_op <= op;
        end
    end

    // valid_out is a one-cycle pulse
    a_pulse: assert property (@(posedge clk) disable iff (rst) valid_out |=> !valid_out)
        else $error("valid_out high for two cycles in a row");

    // Outputs idle in the cycle after reset
    a_reset: assert property (@(posedge clk) rst |=> (!busy && !valid_out))
        else $error("busy or valid_out high right after reset");

    // Only ADD and SUB may report overflow
    a_ovf: assert property (@(posedge clk) disable iff (rst)
        (valid_out && done_op != OP_ADD && done_op != OP_SUB) |-> !ovf)
        else $error("ovf set for an op other than ADD or SUB");

endmodule

//--- tests/alu_unit_tb.sv
// Testbench for alu_unit; run from the project root so tests/alu_golden.mem is found
`timescale 1ns/1ps

module alu_unit_tb import alu_pkg::*; ();
    localparam int NUM_VEC   = 35;
    localparam int NUM_WORDS = NUM_VEC * 5;
    localparam int LAT_LIMIT = 4 * MUL_CYCLES;
    // First vector of each group in the golden file
    localparam int FIRST_CMP   = 9;
    localparam int FIRST_LOGIC = 16;
    localparam int FIRST_MUL   = 26;
    localparam int FIRST_IGN   = 33;
    // Cycle into the multiply where the dropped request is made
    localparam int INTRUDE_AT  = 5;

    logic            clk;
    logic            rst;
    logic            valid_in;
    alu_op_t         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic            busy;
    logic            valid_out;
    logic [XLEN-1:0] result;
    logic            ovf;

    // Five words per vector as op, a, b, result and ovf
    logic [XLEN-1:0] golden [NUM_WORDS];
    logic            golden_ok;
    int              test_errors;
    int              pass_count;
    int              fail_count;

    alu_unit UUT (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .op        (op),
        .a         (a),
        .b         (b),
        .busy      (busy),
        .valid_out (valid_out),
        .result    (result),
        .ovf       (ovf)
    );

    bind alu_unit alu_unit_properties u_props (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .op        (op),
        .busy      (busy),
        .valid_out (valid_out),
        .ovf       (ovf)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %t %s: expected %h, got %h", $time, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic start_test();
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, test_errors);
        end
    endtask

    // Send one vector and optionally slip in a second request while busy
    task automatic run_vector(input int idx, input int intrude_at, input int intruder);
        alu_op_t         v_op;
        logic [XLEN-1:0] v_res;
        logic            v_ovf;
        logic            multi;
        logic            seen;
        int              latency;
        v_op  = alu_op_t'(golden[idx*5][3:0]);
        v_res = golden[idx*5+3];
        v_ovf = golden[idx*5+4][0];
        multi = (v_op == OP_MUL) || (v_op == OP_MULHU);
        @(negedge clk);
        valid_in = 1'b1;
        op       = v_op;
        a        = golden[idx*5+1];
        b        = golden[idx*5+2];
        @(negedge clk);
        valid_in = 1'b0;
        // Latency counts edges after the accepting one
        latency  = 0;
        seen     = 1'b0;
        while (!seen && latency < LAT_LIMIT) begin
            if (valid_out) begin
                seen = 1'b1;
            end else begin
                if (multi) begin
                    check_value("busy", 1, 32'(busy));
                end
                valid_in = (latency == intrude_at);
                if (latency == intrude_at) begin
                    op = alu_op_t'(golden[intruder*5][3:0]);
                    a  = golden[intruder*5+1];
                    b  = golden[intruder*5+2];
                end
                @(negedge clk);
                latency++;
            end
        end
        valid_in = 1'b0;
        if (!seen) begin
            $display("Timeout: vector %0d gave no valid_out within %0d cycles", idx, LAT_LIMIT);
            test_errors++;
        end else begin
            check_value("latency", multi ? MUL_CYCLES + 1 : 0, latency);
            check_value("busy", 0, 32'(busy));
            check_value("result", v_res, result);
            check_value("ovf", 32'(v_ovf), 32'(ovf));
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        rst         = 1'b1;
        valid_in    = 1'b0;
        op          = OP_ADD;
        a           = '0;
        b           = '0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;

        // Fill first so a short file leaves bad words behind
        for (int i = 0; i < NUM_WORDS; i++) begin
            golden[i] = 32'hBAD0_0000 | 32'(i);
        end
        $readmemh("tests/alu_golden.mem", golden);
        golden_ok = 1'b1;
        for (int i = 0; i < NUM_VEC; i++) begin
            if (golden[i*5] > 32'hB || golden[i*5+4] > 32'h1) begin
                golden_ok = 1'b0;
            end
        end

        // Two reset edges and release on the falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test();
        check_value("busy", 0, 32'(busy));
        check_value("valid_out", 0, 32'(valid_out));
        check_value("result", 0, result);
        check_value("ovf", 0, 32'(ovf));
        finish_test("reset");

        if (golden_ok) begin
            start_test();
            for (int i = 0; i < FIRST_CMP; i++) begin
                run_vector(i, -1, 0);
            end
            finish_test("add_sub");

            start_test();
            for (int i = FIRST_CMP; i < FIRST_LOGIC; i++) begin
                run_vector(i, -1, 0);
            end
            finish_test("compare");

            start_test();
            for (int i = FIRST_LOGIC; i < FIRST_MUL; i++) begin
                run_vector(i, -1, 0);
            end
            finish_test("logic_shift");

            start_test();
            for (int i = FIRST_MUL; i < FIRST_IGN; i++) begin
                run_vector(i, -1, 0);
            end
            finish_test("multiply");

            start_test();
            // A MULHU intruder shows whether the pending MUL keeps its own op
            run_vector(FIRST_IGN, INTRUDE_AT, FIRST_IGN - 1);
            // Dropped request must not complete later
            for (int i = 0; i < 4; i++) begin
                @(negedge clk);
                if (valid_out !== 1'b0) begin
                    $display("Extra valid_out at %t after the dropped request", $time);
                    test_errors++;
                end
            end
            // Unit takes new work again
            run_vector(FIRST_IGN + 1, -1, 0);
            finish_test("ignored_request");
        end else begin
            $display("Golden file tests/alu_golden.mem is missing, short or malformed");
            fail_count++;
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- tests/alu_golden.mem
// op a b result ovf, all hex, op codes as in alu_op_t
// Groups: add/sub 0-8, compare 9-15, logic/shift 16-25, multiply 26-32, ignored request 33-34
0 00000001 00000002 00000003 0
0 FFFFFFFF 00000001 00000000 0
0 7FFFFFFF 00000001 80000000 1
0 80000000 80000000 00000000 1
0 12345678 0FEDCBA9 22222221 0
1 00000005 00000005 00000000 0
1 00000000 00000001 FFFFFFFF 0
1 80000000 00000001 7FFFFFFF 1
1 00000003 FFFFFFFE 00000005 0
2 FFFFFFFF 00000001 00000001 0
3 FFFFFFFF 00000001 00000000 0
2 00000001 FFFFFFFF 00000000 0
3 00000001 FFFFFFFF 00000001 0
2 80000000 7FFFFFFF 00000001 0
3 80000000 7FFFFFFF 00000000 0
2 00000007 00000007 00000000 0
4 F0F0F0F0 FF00FF00 F000F000 0
5 F0F0F0F0 0F0F0F0F FFFFFFFF 0
6 AAAAAAAA FFFF0000 5555AAAA 0
7 00000001 0000001F 80000000 0
7 12345678 00000000 12345678 0
7 12345678 00000004 23456780 0
8 80000000 0000001F 00000001 0
8 F0000000 00000004 0F000000 0
9 80000000 0000001F FFFFFFFF 0
9 F0000000 00000004 FF000000 0
A 00000003 00000007 00000015 0
B 00000003 00000007 00000000 0
A FFFFFFFF FFFFFFFF 00000001 0
B FFFFFFFF FFFFFFFF FFFFFFFE 0
A 12345678 00010000 56780000 0
B 12345678 00010000 00001234 0
B 80000000 00000002 00000001 0
A 0000FFFF 0000FFFF FFFE0001 0
0 00000001 00000001 00000002 0

//--- alu_unit.f
verilog/alu_pkg.sv
verilog/ks_adder.sv
verilog/arith_unit.sv
verilog/logic_shift_unit.sv
verilog/shift_add_multiplier.sv
verilog/alu_ctrl.sv
verilog/alu_unit.sv
tests/alu_unit_properties.sv
tests/alu_unit_tb.sv

//--- Makefile
# Verilator build and run for alu_unit, invoked from the project root
TOP := alu_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f alu_unit.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	verilator --lint-only -Wall -f alu_unit.f --top-module alu_unit

clean:
	rm -rf obj_dir
